/* fpu16.f */
+incdir+hw
hw/fpuPkg.sv
hw/fpuNormalizer16.sv
hw/fpuAddSub16.sv
hw/fpuMul16.sv
hw/fpuResultSelect.sv
hw/fpu16.sv
test/fpu16Tb.sv

/* hw/fpu16.sv */
// Binary16 arithmetic unit, top level.
// Operand capture on start, parallel add/sub and multiply paths,
// registered result stage.
`timescale 1ns/1ps

module fpu16 import fpuPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  fpuOp_t     op,
  input  fp16_t      operandA,
  input  fp16_t      operandB,
  output fpuResult_t result,
  output logic       done
);

  fpuOp_t     opReg;
  fp16_t      operandAReg;
  fp16_t      operandBReg;
  logic       issue;
  fpuResult_t addSubResult;
  fpuResult_t mulResult;

  // Capture operands on start.
  always_ff @(posedge clock) begin
    if (reset) begin
      opReg <= opAdd;
      operandAReg <= '0;
      operandBReg <= '0;
    end else if (start) begin
      opReg <= op;
      operandAReg <= operandA;
      operandBReg <= operandB;
    end
  end

  // Issue follows start by one cycle.
  always_ff @(posedge clock) begin
    if (reset) begin
      issue <= 1'b0;
    end else begin
      issue <= start;
    end
  end

  fpuAddSub16 addSub_i (
    .sub   (opReg == opSub),
    .fpuIn1(operandAReg),
    .fpuIn2(operandBReg),
    .result(addSubResult)
  );

  fpuMul16 mul_i (
    .fpuIn1(operandAReg),
    .fpuIn2(operandBReg),
    .result(mulResult)
  );

  fpuResultSelect resultSelect_i (
    .clock       (clock),
    .reset       (reset),
    .issue       (issue),
    .op          (opReg),
    .addSubResult(addSubResult),
    .mulResult   (mulResult),
    .result      (result),
    .done        (done)
  );

endmodule

/* hw/fpu16_defs.svh */
// Binary16 format constants.
// Field widths, exponent bias and the all-ones exponent used for infinity.

`ifndef FPU16_DEFS_SVH
`define FPU16_DEFS_SVH

// Exponent field width.
`define FP16_EXPW 5

// Stored fraction width, hidden bit excluded.
`define FP16_FRACW 10

// Exponent bias.
`define FP16_BIAS 15

// All-ones exponent. Marks infinity.
`define FP16_EXPMAX 31

`endif

/* hw/fpuAddSub16.sv */
// Binary16 adder and subtracter.
// Magnitude sort, alignment with sticky, significand add or subtract,
// normalization and condition codes.
`timescale 1ns/1ps
`include "fpu16_defs.svh"

module fpuAddSub16 import fpuPkg::*; (
  input  logic       sub,
  input  fp16_t      fpuIn1,
  input  fp16_t      fpuIn2,
  output fpuResult_t result
);

  // Hidden bit, fraction and a fraction-wide extension.
  localparam int extW = 2 * `FP16_FRACW + 1;

  logic                  effSign2;
  logic                  swap;
  fp16_t                 largeNum;
  fp16_t                 smallNum;
  logic                  largeSign;
  logic                  smallSign;
  logic [`FP16_EXPW-1:0] largeExp;
  logic [`FP16_EXPW-1:0] smallExp;
  logic [`FP16_EXPW-1:0] expDiff;
  logic [extW-1:0]       largeExt;
  logic [extW-1:0]       smallExt;
  logic [extW-1:0]       smallAligned;
  logic                  alignSticky;
  logic [extW:0]         sum;
  logic                  exactZero;
  logic                  normSign;
  fp16_t                 normalized;

  // Subtraction flips the second operand's sign.
  assign effSign2 = fpuIn2.sign ^ sub;

  // Larger magnitude goes on top.
  assign swap = {fpuIn2.exp, fpuIn2.frac} > {fpuIn1.exp, fpuIn1.frac};
  assign largeNum = swap ? fpuIn2 : fpuIn1;
  assign smallNum = swap ? fpuIn1 : fpuIn2;
  assign largeSign = swap ? effSign2 : fpuIn1.sign;
  assign smallSign = swap ? fpuIn1.sign : effSign2;

  // Subnormals count as exponent 1.
  assign largeExp = (largeNum.exp == '0) ? `FP16_EXPW'(1) : largeNum.exp;
  assign smallExp = (smallNum.exp == '0) ? `FP16_EXPW'(1) : smallNum.exp;
  assign expDiff = largeExp - smallExp;

  assign largeExt = {largeNum.exp != '0, largeNum.frac, `FP16_FRACW'(0)};
  assign smallExt = {smallNum.exp != '0, smallNum.frac, `FP16_FRACW'(0)};

  // Align small significand, keep what falls off as sticky.
  assign smallAligned = smallExt >> expDiff;
  assign alignSticky = |(smallExt & ~({extW{1'b1}} << expDiff));

  // Sticky borrows one unit on subtraction so the rounding stays exact.
  assign sum = (largeSign == smallSign) ?
               ({1'b0, largeExt} + {1'b0, smallAligned}) :
               ({1'b0, largeExt} - {1'b0, smallAligned} - (extW + 1)'(alignSticky));

  // Exact zero is +0 unless both effective signs are negative.
  assign exactZero = (sum == '0) & ~alignSticky;
  assign normSign = exactZero ? (largeSign & smallSign) : largeSign;

  fpuNormalizer16 #(
    .PFW(2 * `FP16_FRACW)
  ) normalizer_i (
    .unnormSign(normSign),
    .unnormInt (sum[extW:extW-1]),
    .unnormFrac(sum[extW-2:0]),
    .unnormExp ({2'b00, largeExp}),
    .sticky    (alignSticky),
    .normOut   (normalized)
  );

  assign result.value = normalized;
  assign result.codes.z = (normalized.exp == '0) & (normalized.frac == '0);
  // Carry out of the integer position.
  assign result.codes.c = sum[extW];
  assign result.codes.n = normalized.sign;
  assign result.codes.v = normalized.exp == `FP16_EXPW'(`FP16_EXPMAX);

endmodule

/* hw/fpuMul16.sv */
// Binary16 multiplier.
// Significand product, exponent sum, normalization and condition codes.
`timescale 1ns/1ps
`include "fpu16_defs.svh"

module fpuMul16 import fpuPkg::*; (
  input  fp16_t      fpuIn1,
  input  fp16_t      fpuIn2,
  output fpuResult_t result
);

  localparam int sigW = `FP16_FRACW + 1;
  localparam int prodW = 2 * sigW;

  logic [sigW-1:0]       sig1;
  logic [sigW-1:0]       sig2;
  logic [`FP16_EXPW-1:0] exp1;
  logic [`FP16_EXPW-1:0] exp2;
  logic [prodW-1:0]      product;
  logic signed [6:0]     prodExp;
  fp16_t                 normalized;

  // Hidden bit only for normal operands.
  assign sig1 = {fpuIn1.exp != '0, fpuIn1.frac};
  assign sig2 = {fpuIn2.exp != '0, fpuIn2.frac};

  // Subnormals count as exponent 1.
  assign exp1 = (fpuIn1.exp == '0) ? `FP16_EXPW'(1) : fpuIn1.exp;
  assign exp2 = (fpuIn2.exp == '0) ? `FP16_EXPW'(1) : fpuIn2.exp;

  // Two integer bits and twice the fraction width.
  assign product = prodW'(sig1) * prodW'(sig2);

  // Can go negative for small operands.
  assign prodExp = 7'(exp1) + 7'(exp2) - 7'(`FP16_BIAS);

  // Product is exact, so no sticky.
  fpuNormalizer16 #(
    .PFW(prodW)
  ) normalizer_i (
    .unnormSign(fpuIn1.sign ^ fpuIn2.sign),
    .unnormInt (product[prodW-1 -: 2]),
    .unnormFrac({product[prodW-3:0], 2'b00}),
    .unnormExp (prodExp),
    .sticky    (1'b0),
    .normOut   (normalized)
  );

  assign result.value = normalized;
  assign result.codes.z = (normalized.exp == '0) & (normalized.frac == '0);
  // No carry flag for multiply.
  assign result.codes.c = 1'b0;
  assign result.codes.n = normalized.sign;
  assign result.codes.v = normalized.exp == `FP16_EXPW'(`FP16_EXPMAX);

endmodule

/* hw/fpuNormalizer16.sv */
// Normalizer for binary16 results.
// Leading-one search, alignment with subnormal bound, nearest-even rounding,
// overflow saturation and packing.
`timescale 1ns/1ps
`include "fpu16_defs.svh"

module fpuNormalizer16 import fpuPkg::*; #(
  parameter int PFW = 20
) (
  input  logic              unnormSign,
  input  logic [1:0]        unnormInt,
  input  logic [PFW-1:0]    unnormFrac,
  input  logic signed [6:0] unnormExp,
  input  logic              sticky,
  output fp16_t             normOut
);

  localparam int sigW = PFW + 2;
  localparam int mantW = `FP16_FRACW + 1;
  // Guard bit sits just below the last kept fraction bit.
  localparam int guardPos = PFW - `FP16_FRACW - 1;
  localparam logic signed [7:0] expMax = 8'(`FP16_EXPMAX);

  logic [sigW-1:0]        sig;
  logic signed [7:0]      leadPos;
  logic signed [7:0]      expIn;
  logic signed [7:0]      normShift;
  logic signed [7:0]      subShift;
  logic signed [7:0]      rShift;
  logic [7:0]             shAmt;
  logic [sigW-1:0]        shifted;
  logic                   lostBits;
  logic [mantW-1:0]       mant;
  logic                   guardBit;
  logic                   roundBit;
  logic                   stickyAll;
  logic                   roundUp;
  logic [mantW:0]         rounded;
  logic signed [7:0]      expNorm;
  logic signed [7:0]      expRound;
  logic [`FP16_FRACW-1:0] fracRound;

  assign sig = {unnormInt, unnormFrac};
  assign expIn = 8'(unnormExp);

  // Highest set bit of the significand.
  always_comb begin
    leadPos = '0;
    for (int i = 0; i < sigW; i++) begin
      if (sig[i]) begin
        leadPos = 8'(i);
      end
    end
  end

  // Right shift that lands the leading one on the hidden bit.
  assign normShift = leadPos - 8'(PFW);
  // Smallest shift that keeps the exponent at 1.
  assign subShift = 8'sd1 - expIn;
  // Whichever is larger wins, so tiny values go subnormal.
  assign rShift = (normShift > subShift) ? normShift : subShift;
  assign shAmt = rShift[7] ? 8'(-rShift) : rShift;

  always_comb begin
    if (rShift[7]) begin
      shifted = sig << shAmt;
      lostBits = 1'b0;
    end else begin
      shifted = sig >> shAmt;
      // Bits pushed below the field feed the sticky.
      lostBits = |(sig & ~({sigW{1'b1}} << shAmt));
    end
  end

  // Hidden bit plus stored fraction, then guard, round, sticky.
  assign mant = shifted[PFW -: mantW];
  assign guardBit = shifted[guardPos];
  assign roundBit = shifted[guardPos - 1];
  assign stickyAll = (|shifted[guardPos - 2:0]) | lostBits | sticky;
  // Ties go to the even mantissa.
  assign roundUp = guardBit & (roundBit | stickyAll | mant[0]);
  assign rounded = {1'b0, mant} + (mantW + 1)'(roundUp);

  assign expNorm = expIn + rShift;

  always_comb begin
    if (rounded[mantW]) begin
      // Rounding carried to 2.0, renormalize.
      expRound = expNorm + 8'sd1;
      fracRound = rounded[mantW-1:1];
    end else begin
      // No hidden bit means subnormal or zero.
      expRound = rounded[mantW-1] ? expNorm : 8'sd0;
      fracRound = rounded[`FP16_FRACW-1:0];
    end
  end

  always_comb begin
    normOut.sign = unnormSign;
    if (expRound >= expMax) begin
      // Saturate to signed infinity.
      normOut.exp = `FP16_EXPW'(`FP16_EXPMAX);
      normOut.frac = '0;
    end else begin
      normOut.exp = expRound[`FP16_EXPW-1:0];
      normOut.frac = fracRound;
    end
  end

endmodule

/* hw/fpuPkg.sv */
// Shared types for the binary16 unit.
// Operand layout, condition codes, opcodes and the packed result.

package fpuPkg;

  `include "fpu16_defs.svh"

  // IEEE binary16 operand.
  typedef struct packed {
    logic                    sign;
    logic [`FP16_EXPW-1:0]   exp;
    logic [`FP16_FRACW-1:0]  frac;
  } fp16_t;

  // Zero, carry, negative, overflow.
  typedef struct packed {
    logic z;
    logic c;
    logic n;
    logic v;
  } condCode_t;

  typedef enum logic [1:0] {
    opAdd,
    opSub,
    opMul
  } fpuOp_t;

  // Value and its flags travel together.
  typedef struct packed {
    fp16_t     value;
    condCode_t codes;
  } fpuResult_t;

endpackage

/* hw/fpuResultSelect.sv */
// Result stage.
// Picks the multiplier or adder result by opcode and registers it
// together with the done strobe.
`timescale 1ns/1ps

module fpuResultSelect import fpuPkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       issue,
  input  fpuOp_t     op,
  input  fpuResult_t addSubResult,
  input  fpuResult_t mulResult,
  output fpuResult_t result,
  output logic       done
);

  fpuResult_t chosen;

  // Add and subtract share one path.
  assign chosen = (op == opMul) ? mulResult : addSubResult;

  // Result only moves on issue, so it holds until the next done.
  always_ff @(posedge clock) begin
    if (reset) begin
      result <= '0;
    end else if (issue) begin
      result <= chosen;
    end
  end

  // One done per issue, one cycle later.
  always_ff @(posedge clock) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= issue;
    end
  end

endmodule

/* runSim.sh */
#!/usr/bin/env bash
# Builds the fpu16 testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

top=fpu16Tb
logFile=sim.log

verilator --binary --timing --top-module "$top" -f fpu16.f -o "$top"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/"$top" > "$logFile" 2>&1
status=$?
cat "$logFile"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^NO ERRORS$" "$logFile"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see $logFile"
  exit 1
fi

/* test/fpu16Tb.sv */
// Testbench for the binary16 unit.
// Vector file reader, gapped and back-to-back stimulus,
// in-order result checks with latency and timeout tracking.
`timescale 1ns/1ps

module fpu16Tb import fpuPkg::*; ();

  localparam int maxVectors = 64;

  logic       clock = 1'b0;
  logic       reset;
  logic       start;
  fpuOp_t     op;
  fp16_t      operandA;
  fp16_t      operandB;
  fpuResult_t result;
  logic       done;

  // Vector storage.
  logic [1:0]  vecOp [maxVectors];
  logic [15:0] vecA [maxVectors];
  logic [15:0] vecB [maxVectors];
  logic [15:0] vecRes [maxVectors];
  logic [3:0]  vecCodes [maxVectors];
  int          vecCount = 0;

  // Operations in flight in start order.
  int pendIdx[$];
  int pendCycle[$];

  // Result seen on the latest done.
  fpuResult_t lastResult = '0;

  integer seed = 32'h623ef64e;
  bit     burstMode = 1'b0;
  int     cycleCount = 0;
  int     passCount = 0;
  int     failCount = 0;
  int     setupErrors = 0;

  fpu16 fpu16_i (
    .clock   (clock),
    .reset   (reset),
    .start   (start),
    .op      (op),
    .operandA(operandA),
    .operandB(operandB),
    .result  (result),
    .done    (done)
  );

  // 4 ns period.
  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycleCount <= cycleCount + 1;
  end

  function automatic string opName(logic [1:0] code);
    case (code)
      2'd0: return "add";
      2'd1: return "sub";
      2'd2: return "mul";
      default: return "bad";
    endcase
  endfunction

  function automatic string testName(int idx);
    string mode;
    mode = burstMode ? "burst" : "gapped";
    return $sformatf("%s %s #%0d", mode, opName(vecOp[idx]), idx);
  endfunction

  // Comment lines start with a hash.
  task automatic loadVectors(int fd);
    string      line;
    int         n;
    logic [1:0] tOp;
    logic [15:0] tA;
    logic [15:0] tB;
    logic [15:0] tRes;
    logic [3:0]  tCodes;
    while (!$feof(fd) && vecCount < maxVectors) begin
      n = $fgets(line, fd);
      if (n > 0 && line[0] != "#") begin
        if ($sscanf(line, "%h %h %h %h %h", tOp, tA, tB, tRes, tCodes) == 5) begin
          vecOp[vecCount] = tOp;
          vecA[vecCount] = tA;
          vecB[vecCount] = tB;
          vecRes[vecCount] = tRes;
          vecCodes[vecCount] = tCodes;
          vecCount++;
        end
      end
    end
    if (vecCount == 0) begin
      $display("No vectors were read from test/fpu16_vectors.txt");
      setupErrors++;
    end
  endtask

  task automatic applyReset();
    for (int c = 0; c < 8; c++) begin
      @(posedge clock);
    end
    reset <= 1'b0;
  endtask

  // Random idle gaps of 0 to 3 cycles in gapped mode only.
  task automatic runVectors();
    int gap;
    for (int i = 0; i < vecCount; i++) begin
      gap = burstMode ? 0 : ($random(seed) & 32'h3);
      for (int g = 0; g < gap; g++) begin
        @(posedge clock);
        start <= 1'b0;
      end
      @(posedge clock);
      start <= 1'b1;
      op <= fpuOp_t'(vecOp[i]);
      operandA <= vecA[i];
      operandB <= vecB[i];
      pendIdx.push_back(i);
      // Start is seen high in the next cycle.
      pendCycle.push_back(cycleCount + 1);
    end
    @(posedge clock);
    start <= 1'b0;
  endtask

  task automatic drainPending();
    int waited;
    waited = 0;
    while (pendIdx.size() > 0 && waited < 20) begin
      @(posedge clock);
      waited++;
    end
    if (pendIdx.size() > 0) begin
      $display("Operations still in flight 20 cycles after the last start");
      setupErrors++;
    end
  endtask

  // Outputs are sampled mid-cycle.
  always @(negedge clock) begin
    int    idx;
    int    startAt;
    string name;
    if (reset) begin
      if (done) begin
        $display("done went high during reset at cycle %0d", cycleCount);
        failCount++;
      end
      if (result != '0) begin
        $display("result was not cleared by reset at cycle %0d", cycleCount);
        failCount++;
      end
    end else if (done) begin
      if (pendIdx.size() == 0) begin
        $display("done went high with no operation in flight at cycle %0d", cycleCount);
        failCount++;
      end else begin
        idx = pendIdx.pop_front();
        startAt = pendCycle.pop_front();
        name = testName(idx);
        // Two cycles from start to done.
        if (cycleCount != startAt + 2) begin
          $display("Fail %s: expected done in cycle %0d, actual cycle %0d",
                   name, startAt + 2, cycleCount);
          failCount++;
        end else if (result.value != vecRes[idx] || result.codes != vecCodes[idx]) begin
          $display("Fail %s: expected %h codes %b, actual %h codes %b",
                   name, vecRes[idx], vecCodes[idx], result.value, result.codes);
          failCount++;
        end else begin
          $display("ok %s: value %h codes %b", name, result.value, result.codes);
          passCount++;
        end
      end
      lastResult = result;
    end else begin
      // Result holds between dones.
      if (result != lastResult) begin
        $display("result changed without done at cycle %0d", cycleCount);
        failCount++;
      end
      if (pendCycle.size() > 0 && cycleCount > pendCycle[0] + 20) begin
        $display("No done within 20 cycles after start of %s", testName(pendIdx[0]));
        $display("ERRORS FOUND");
        $finish;
      end
    end
  end

  initial begin
    int fd;
    reset <= 1'b1;
    start <= 1'b0;
    op <= opAdd;
    operandA <= '0;
    operandB <= '0;
    fd = $fopen("test/fpu16_vectors.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the vector file test/fpu16_vectors.txt");
      $display("ERRORS FOUND");
      $finish;
    end else begin
      loadVectors(fd);
      $fclose(fd);
      applyReset();
      // First pass with idle gaps, second with a start every cycle.
      burstMode = 1'b0;
      runVectors();
      drainPending();
      burstMode = 1'b1;
      runVectors();
      drainPending();
      // Trailing idle cycles keep done low.
      for (int c = 0; c < 4; c++) begin
        @(posedge clock);
      end
      $display("Tests passed: %0d, failed: %0d, other errors: %0d",
               passCount, failCount, setupErrors);
      if (failCount + setupErrors == 0) begin
        $display("NO ERRORS");
      end else begin
        $display("ERRORS FOUND");
      end
      $finish;
    end
  end

endmodule

/* test/fpu16_vectors.txt */
# Columns in hex: op (0 add, 1 sub, 2 mul), operand A, operand B, expected result, codes.
# Codes from high bit to low bit: Z C N V.
# Add and subtract, carry and nearest-even ties
0 3c00 3c00 4000 4
0 3e00 3e00 4200 4
0 3c00 3800 3e00 0
1 4200 3c00 4000 0
1 3c00 4200 c000 2
0 3c00 1000 3c00 0
0 3c01 1000 3c02 0
0 3c00 1200 3c01 0
# Cancellation, signed zeros and subnormal results
1 3e00 3e00 0000 8
0 3c00 bc00 0000 8
0 8000 8000 8000 a
1 3c01 3c00 1400 0
1 0401 0400 0001 0
1 0600 0400 0200 0
1 4000 1000 4000 0
# Multiplication with normal, subnormal and mixed-sign operands
2 3e00 3e00 4080 0
2 c000 4200 c600 2
2 3800 b800 b400 2
2 0200 4000 0400 0
2 1400 1400 0010 0
2 0400 1000 0000 8
2 8400 1000 8000 a
# Overflow to signed infinity
0 7bff 7bff 7c00 5
0 fbff fbff fc00 7
0 7bff 4c00 7c00 1
0 7bff 4800 7bff 0
2 5c00 5c00 7c00 1
2 dc00 5c00 fc00 3
